//--- core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register file sizes
`define XLEN      32
`define NUM_ARCH  8     // architectural registers
`define NUM_PHYS  16    // physical registers, twice the arch count

// buffer depths
`define ROB_DEPTH 8     // power of two, pointers wrap on their own
`define IQ_DEPTH  4

`define MUL_LAT   3     // issue to result bus, in edges
`define ZERO_REG  0     // never renamed, reads as zero

`endif

//--- core_pkg.sv
`include "core_macros.svh"

package core_pkg;

	// halt is the top legal code, everything above it is illegal
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_MUL  = 4'd6,
		OP_HALT = 4'd7
	} opcode_e;

	typedef enum logic [1:0] {RUN, DRAIN, HALTED} core_state_e;

	// also used as the commit kind, normal / halt / illegal
	typedef enum logic [1:0] {NO_ERROR, HALTED_ON_HALT, HALTED_ON_ILLEGAL} halt_status_e;

	typedef logic [$clog2(`NUM_ARCH)-1:0]  arch_idx_t;
	typedef logic [$clog2(`NUM_PHYS)-1:0]  phys_idx_t;
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

	typedef struct packed {
		logic [3:0]       opcode;  // raw, decoded in core_ctrl
		arch_idx_t        dest;
		arch_idx_t        src_a;
		arch_idx_t        src_b;
		logic [`XLEN-1:0] imm;
	} dispatch_t;

	typedef struct packed {
		opcode_e          op;
		phys_idx_t        tag_a;
		phys_idx_t        tag_b;
		phys_idx_t        dest;   // 0 when nothing is written
		logic             rdy_a;
		logic [`XLEN-1:0] val_a;
		logic             rdy_b;
		logic [`XLEN-1:0] val_b;  // immediate for addi
		rob_idx_t         rob_idx;
	} renamed_t;

	typedef struct packed {
		logic             valid;
		phys_idx_t        tag;
		rob_idx_t         rob_idx;
		logic [`XLEN-1:0] value;
	} cdb_t;

	typedef struct packed {
		arch_idx_t        dest;
		logic             wr_en;
		logic [`XLEN-1:0] value;
	} commit_t;

endpackage

//--- core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   disp_valid,
	input  logic [3:0]             disp_opcode,   // raw field from the instruction
	input  logic                   free_empty,
	input  logic                   rob_full,
	input  logic                   iq_full,
	input  logic                   commit_valid,
	input  core_pkg::halt_status_e commit_kind,
	output logic                   disp_fire,
	output core_pkg::opcode_e      disp_op,
	output logic                   disp_illegal,
	output logic                   stall,
	output core_pkg::halt_status_e halt_status
);
	import core_pkg::*;

	core_state_e state;

	// an illegal code decodes as a halt downstream
	always_comb begin
		disp_illegal = 1'b0;
		case (disp_opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL, OP_HALT:
				disp_op = opcode_e'(disp_opcode);
			default: begin
				disp_op      = OP_HALT;
				disp_illegal = 1'b1;
			end
		endcase
	end

	assign stall     = free_empty | rob_full | iq_full | (state != RUN);
	assign disp_fire = disp_valid & ~stall;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state       <= RUN;
			halt_status <= NO_ERROR;
		end else begin
			case (state)
				RUN:    if (disp_fire && disp_op == OP_HALT) state <= DRAIN;  // stop taking new work
				DRAIN:  if (commit_valid && commit_kind != NO_ERROR) begin
					state       <= HALTED;
					halt_status <= commit_kind;  // halt or illegal reached the head
				end
				default: state <= HALTED;        // sticky until reset
			endcase
		end
	end

	// a halted core retires nothing
	a_no_commit_when_halted: assert property (@(posedge clock) disable iff (!rst_n)
		(state == HALTED) |-> !commit_valid);

endmodule

//--- rename_map.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module rename_map (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                disp_fire,
	input  core_pkg::dispatch_t disp_inst,
	output core_pkg::phys_idx_t src_a_tag,
	output core_pkg::phys_idx_t src_b_tag,
	output core_pkg::phys_idx_t dest_tag,    // 0 when no register is allocated
	output core_pkg::phys_idx_t prev_tag,
	output logic                free_empty,
	input  logic                free_valid,  // from commit
	input  core_pkg::phys_idx_t free_tag
);
	import core_pkg::*;

	phys_idx_t            map_q [`NUM_ARCH];
	logic [`NUM_PHYS-1:0] free_map;      // 1 = free
	phys_idx_t            low_free;
	logic                 needs_dest;

	// lowest free physical register
	always_comb begin
		low_free = '0;
		for (int i = `NUM_PHYS-1; i >= 0; i--)
			if (free_map[i]) low_free = phys_idx_t'(i);
	end

	// halt sits at the top of the legal codes, illegal ones lie above it
	assign needs_dest = (disp_inst.dest != `ZERO_REG) && (disp_inst.opcode < 4'(OP_HALT));

	assign src_a_tag  = map_q[disp_inst.src_a];
	assign src_b_tag  = map_q[disp_inst.src_b];
	assign prev_tag   = map_q[disp_inst.dest];  // freed when this one commits
	assign dest_tag   = needs_dest ? low_free : phys_idx_t'(0);
	assign free_empty = ~|free_map;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_ARCH; i++) map_q[i] <= phys_idx_t'(i);  // identity
			for (int i = 0; i < `NUM_PHYS; i++) free_map[i] <= (i >= `NUM_ARCH);
		end else begin
			if (free_valid) free_map[free_tag] <= 1'b1;
			if (disp_fire && needs_dest) begin
				free_map[low_free]     <= 1'b0;
				map_q[disp_inst.dest]  <= low_free;
			end
		end
	end

	// a committed instruction only gives back a register that was in use
	a_no_double_free: assert property (@(posedge clock) disable iff (!rst_n)
		free_valid |-> !free_map[free_tag]);

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module phys_regfile (
	input  logic                clock,
	input  logic                rst_n,
	input  core_pkg::phys_idx_t src_a_tag,
	input  core_pkg::phys_idx_t src_b_tag,
	input  logic                alloc_valid,
	input  core_pkg::phys_idx_t alloc_tag,
	input  core_pkg::cdb_t      cdb,
	output logic [`XLEN-1:0]    src_a_val,
	output logic                src_a_rdy,
	output logic [`XLEN-1:0]    src_b_val,
	output logic                src_b_rdy
);
	import core_pkg::*;

	logic [`XLEN-1:0]     vals [`NUM_PHYS];
	logic [`NUM_PHYS-1:0] rdy;
	logic                 fwd_a, fwd_b;

	// bus beat bypass, tag 0 is the zero register and never takes a write
	assign fwd_a = cdb.valid && (cdb.tag == src_a_tag) && (src_a_tag != '0);
	assign fwd_b = cdb.valid && (cdb.tag == src_b_tag) && (src_b_tag != '0);

	assign src_a_val = fwd_a ? cdb.value : vals[src_a_tag];
	assign src_a_rdy = fwd_a | rdy[src_a_tag];
	assign src_b_val = fwd_b ? cdb.value : vals[src_b_tag];
	assign src_b_rdy = fwd_b | rdy[src_b_tag];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_PHYS; i++) vals[i] <= '0;  // arch state starts at zero
			rdy <= '1;
		end else begin
			if (cdb.valid && cdb.tag != '0) begin
				vals[cdb.tag] <= cdb.value;
				rdy[cdb.tag]  <= 1'b1;
			end
			if (alloc_valid && alloc_tag != '0) rdy[alloc_tag] <= 1'b0;  // waits for its producer
		end
	end

endmodule

//--- issue_queue.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module issue_queue (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               disp_fire,
	input  core_pkg::renamed_t renamed,
	input  core_pkg::cdb_t     cdb,
	input  logic               wb_slot_busy,  // a multiply owns next bus cycle
	output logic               iq_full,
	output logic               issue_valid,
	output core_pkg::renamed_t issue_op
);
	import core_pkg::*;

	localparam int CW = $clog2(`IQ_DEPTH) + 1;
	typedef logic [$clog2(`IQ_DEPTH)-1:0] slot_t;

	renamed_t q      [`IQ_DEPTH];  // slot 0 is the oldest
	renamed_t woke   [`IQ_DEPTH];
	renamed_t q_next [`IQ_DEPTH];
	logic [CW-1:0] cnt, cnt_next;
	slot_t         sel;

	// capture a bus beat into waiting operands
	always_comb begin
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			woke[i] = q[i];
			if (cdb.valid && !q[i].rdy_a && q[i].tag_a == cdb.tag) begin
				woke[i].rdy_a = 1'b1;
				woke[i].val_a = cdb.value;
			end
			if (cdb.valid && !q[i].rdy_b && q[i].tag_b == cdb.tag) begin
				woke[i].rdy_b = 1'b1;
				woke[i].val_b = cdb.value;
			end
		end
	end

	// oldest ready wins, walk from the top so slot 0 ends up on top
	always_comb begin
		issue_valid = 1'b0;
		sel         = '0;
		for (int i = `IQ_DEPTH-1; i >= 0; i--) begin
			if (i < cnt && woke[i].rdy_a && woke[i].rdy_b &&
			    (woke[i].op == OP_MUL || !wb_slot_busy)) begin
				issue_valid = 1'b1;
				sel         = slot_t'(i);
			end
		end
	end

	assign issue_op = woke[sel];
	assign iq_full  = (cnt == CW'(`IQ_DEPTH));

	// close the gap left by the issued entry, then append
	always_comb begin
		for (int i = 0; i < `IQ_DEPTH-1; i++)
			q_next[i] = (issue_valid && i >= sel) ? woke[i+1] : woke[i];
		q_next[`IQ_DEPTH-1] = woke[`IQ_DEPTH-1];
		cnt_next = cnt - CW'(issue_valid);
		if (disp_fire && renamed.op != OP_HALT) begin  // halt / illegal never execute
			q_next[slot_t'(cnt_next)] = renamed;
			cnt_next                  = cnt_next + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) cnt <= '0;
		else        cnt <= cnt_next;
	end

	always_ff @(posedge clock) q <= q_next;

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  core_pkg::renamed_t issue_op,
	output logic               wb_slot_busy,
	output core_pkg::cdb_t     cdb           // registered result bus
);
	import core_pkg::*;

	cdb_t               mul_pipe [`MUL_LAT-1];  // last stage is the bus register itself
	logic [`XLEN-1:0]   alu_val;
	logic               alu_issue, mul_issue;

	assign alu_issue = issue_valid && issue_op.op != OP_MUL;
	assign mul_issue = issue_valid && issue_op.op == OP_MUL;

	always_comb begin
		case (issue_op.op)
			OP_SUB:  alu_val = issue_op.val_a - issue_op.val_b;
			OP_AND:  alu_val = issue_op.val_a & issue_op.val_b;
			OP_OR:   alu_val = issue_op.val_a | issue_op.val_b;
			OP_XOR:  alu_val = issue_op.val_a ^ issue_op.val_b;
			default: alu_val = issue_op.val_a + issue_op.val_b;  // add, addi
		endcase
	end

	// a multiply in the last pipe stage lands on the bus at the next edge
	assign wb_slot_busy = mul_pipe[`MUL_LAT-2].valid;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cdb <= '0;
			for (int i = 0; i < `MUL_LAT-1; i++) mul_pipe[i] <= '0;
		end else begin
			mul_pipe[0] <= '{mul_issue, issue_op.dest, issue_op.rob_idx,
			                  issue_op.val_a * issue_op.val_b};  // low half only
			for (int i = 1; i < `MUL_LAT-1; i++) mul_pipe[i] <= mul_pipe[i-1];
			if (alu_issue) cdb <= '{1'b1, issue_op.dest, issue_op.rob_idx, alu_val};
			else           cdb <= mul_pipe[`MUL_LAT-2];
		end
	end

	// the queue must hold back alu ops when a multiply is about to finish
	a_one_result_per_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		alu_issue |-> !wb_slot_busy);

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reorder_buffer (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   disp_fire,
	input  core_pkg::arch_idx_t    disp_dest,
	input  core_pkg::phys_idx_t    dest_tag,
	input  core_pkg::phys_idx_t    prev_tag,
	input  core_pkg::halt_status_e disp_kind,
	output core_pkg::rob_idx_t     alloc_idx,
	input  core_pkg::cdb_t         cdb,
	output logic                   rob_full,
	output logic                   commit_valid,
	output core_pkg::commit_t      commit,
	output core_pkg::halt_status_e commit_kind,
	output logic                   free_valid,
	output core_pkg::phys_idx_t    free_tag
);
	import core_pkg::*;

	arch_idx_t        arch_q [`ROB_DEPTH];
	phys_idx_t        tag_q  [`ROB_DEPTH];
	phys_idx_t        prev_q [`ROB_DEPTH];
	halt_status_e     kind_q [`ROB_DEPTH];
	logic [`XLEN-1:0] val_q  [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0]       done;
	rob_idx_t                    head, tail;
	logic [$clog2(`ROB_DEPTH):0] count;

	assign alloc_idx    = tail;
	assign rob_full     = (count == `ROB_DEPTH);
	assign commit_valid = (count != '0) && done[head];  // in order, head only
	assign commit.dest  = arch_q[head];
	assign commit.wr_en = (arch_q[head] != `ZERO_REG);
	assign commit.value = val_q[head];
	assign commit_kind  = kind_q[head];
	assign free_valid   = commit_valid && commit.wr_en;
	assign free_tag     = prev_q[head];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (disp_fire) begin
				arch_q[tail] <= (disp_kind == NO_ERROR) ? disp_dest : arch_idx_t'(`ZERO_REG);
				tag_q[tail]  <= dest_tag;
				prev_q[tail] <= prev_tag;
				kind_q[tail] <= disp_kind;
				val_q[tail]  <= '0;
				done[tail]   <= (disp_kind != NO_ERROR);  // nothing to execute
				tail         <= tail + 1'b1;
			end
			if (cdb.valid) begin
				done[cdb.rob_idx]  <= 1'b1;
				val_q[cdb.rob_idx] <= cdb.value;
			end
			if (commit_valid) head <= head + 1'b1;
			case ({disp_fire, commit_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// a result returns to the entry whose rename gave out its tag
	a_cdb_tag_match: assert property (@(posedge clock) disable iff (!rst_n)
		cdb.valid |-> (cdb.tag == tag_q[cdb.rob_idx]) && !done[cdb.rob_idx]);

endmodule

//--- ooo_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module ooo_core (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   disp_valid,    // dispatch strobe
	input  core_pkg::dispatch_t    disp_inst,     // held by the source while stall
	output logic                   stall,
	output logic                   commit_valid,  // one-cycle pulse per commit
	output core_pkg::commit_t      commit,
	output core_pkg::halt_status_e halt_status
);
	import core_pkg::*;

	logic         disp_fire;
	opcode_e      disp_op;
	logic         disp_illegal;
	halt_status_e disp_kind;
	logic         free_empty, rob_full, iq_full;
	halt_status_e commit_kind;
	phys_idx_t    src_a_tag, src_b_tag, dest_tag, prev_tag;
	logic         free_valid;
	phys_idx_t    free_tag;
	logic [`XLEN-1:0] src_a_val, src_b_val;
	logic         src_a_rdy, src_b_rdy;
	rob_idx_t     alloc_idx;
	renamed_t     renamed;
	renamed_t     issue_op;
	logic         issue_valid;
	logic         wb_slot_busy;
	cdb_t         cdb;

	assign disp_kind = disp_illegal ? HALTED_ON_ILLEGAL :
	                   (disp_op == OP_HALT) ? HALTED_ON_HALT : NO_ERROR;

	// addi takes its immediate as operand b of the queue entry
	always_comb begin
		renamed.op      = disp_op;
		renamed.tag_a   = src_a_tag;
		renamed.tag_b   = src_b_tag;
		renamed.dest    = dest_tag;
		renamed.rdy_a   = src_a_rdy;
		renamed.val_a   = src_a_val;
		renamed.rdy_b   = (disp_op == OP_ADDI) | src_b_rdy;
		renamed.val_b   = (disp_op == OP_ADDI) ? disp_inst.imm : src_b_val;
		renamed.rob_idx = alloc_idx;
	end

	////////////////////////////////////////////////////////////////////////////
	// control and rename
	////////////////////////////////////////////////////////////////////////////
	core_ctrl i_ctrl (
		.clock(clock), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_opcode(disp_inst.opcode),
		.free_empty(free_empty), .rob_full(rob_full), .iq_full(iq_full),
		.commit_valid(commit_valid), .commit_kind(commit_kind),
		.disp_fire(disp_fire), .disp_op(disp_op), .disp_illegal(disp_illegal),
		.stall(stall), .halt_status(halt_status)
	);

	rename_map i_rename (
		.clock(clock), .rst_n(rst_n),
		.disp_fire(disp_fire), .disp_inst(disp_inst),
		.src_a_tag(src_a_tag), .src_b_tag(src_b_tag),
		.dest_tag(dest_tag), .prev_tag(prev_tag), .free_empty(free_empty),
		.free_valid(free_valid), .free_tag(free_tag)
	);

	phys_regfile i_prf (
		.clock(clock), .rst_n(rst_n),
		.src_a_tag(src_a_tag), .src_b_tag(src_b_tag),
		.alloc_valid(disp_fire), .alloc_tag(dest_tag),   // tag 0 means no alloc
		.cdb(cdb),
		.src_a_val(src_a_val), .src_a_rdy(src_a_rdy),
		.src_b_val(src_b_val), .src_b_rdy(src_b_rdy)
	);

	////////////////////////////////////////////////////////////////////////////
	// issue, execute, retire
	////////////////////////////////////////////////////////////////////////////
	issue_queue i_iq (
		.clock(clock), .rst_n(rst_n),
		.disp_fire(disp_fire), .renamed(renamed), .cdb(cdb),
		.wb_slot_busy(wb_slot_busy), .iq_full(iq_full),
		.issue_valid(issue_valid), .issue_op(issue_op)
	);

	exec_unit i_ex (
		.clock(clock), .rst_n(rst_n),
		.issue_valid(issue_valid), .issue_op(issue_op),
		.wb_slot_busy(wb_slot_busy), .cdb(cdb)
	);

	reorder_buffer i_rob (
		.clock(clock), .rst_n(rst_n),
		.disp_fire(disp_fire), .disp_dest(disp_inst.dest),
		.dest_tag(dest_tag), .prev_tag(prev_tag), .disp_kind(disp_kind),
		.alloc_idx(alloc_idx), .cdb(cdb), .rob_full(rob_full),
		.commit_valid(commit_valid), .commit(commit), .commit_kind(commit_kind),
		.free_valid(free_valid), .free_tag(free_tag)
	);

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_checker #(
	parameter int MAX_LINES = 64
) (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   commit_valid,
	input  core_pkg::commit_t      commit,
	input  core_pkg::halt_status_e halt_status,
	input  logic [7:0]             test_id,
	input  logic                   test_end,      // closes the current test
	input  logic                   run_end,
	output logic                   test_drained,  // every line of the test committed
	output int                     err_count
);
	import core_pkg::*;

	localparam int W = 8;

	logic [31:0]  stim [MAX_LINES*W];
	int           first = 0;          // first line of the current test
	int           count = 0;          // lines in the current test
	int           seen = 0;           // commits so far
	int           test_err = 0;
	int           stall_cycles = 0;
	int           tests_run = 0;
	int           tests_failed = 0;
	int           errors = 0;
	int           row;
	halt_status_e exp_status;

	initial $readmemh("stim_core.txt", stim);

	assign test_drained = rst_n && (count != 0) && (seen == count);
	assign err_count    = errors;

	// opcode 7 halts, anything above it is illegal
	function automatic halt_status_e expected_status(input logic [31:0] opc);
		if (opc == 32'd7)
			return HALTED_ON_HALT;
		else if (opc > 32'd7)
			return HALTED_ON_ILLEGAL;
		else
			return NO_ERROR;
	endfunction

	task automatic note_error();
		errors++;
		test_err++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per-commit compare, in program order
	////////////////////////////////////////////////////////////////////////////
	task automatic check_commit();
		if (seen >= count) begin
			$display("time %0t: test %0d committed more instructions than it dispatched",
			         $time, test_id);
			note_error();
		end else begin
			row = (first + seen) * W;
			// dest and value only matter when the write is enabled
			if (commit.wr_en !== stim[row+6][0] || (stim[row+6][0] &&
			    (commit.dest !== stim[row+2][2:0] || commit.value !== stim[row+7]))) begin
				$display("[ERROR] %0t: test %0d instr %0d got we=%0b r%0d=%h, exp we=%0b r%0d=%h",
				         $time, test_id, seen, commit.wr_en, commit.dest, commit.value,
				         stim[row+6][0], stim[row+2][2:0], stim[row+7]);
				note_error();
			end
			seen++;
		end
	endtask

	task automatic finish_test();
		exp_status = expected_status(stim[(first+count-1)*W+1]);
		if (seen != count) begin
			$display("time %0t: test %0d committed only %0d of %0d instructions",
			         $time, test_id, seen, count);
			note_error();
		end
		if (halt_status != exp_status) begin
			$display("[ERROR] %0t: test %0d halt status %s, expected %s",
			         $time, test_id, halt_status.name(), exp_status.name());
			note_error();
		end
		if (count > `ROB_DEPTH && stall_cycles == 0) begin  // burst must back up
			$display("time %0t: test %0d burst longer than the reorder buffer never stalled",
			         $time, test_id);
			note_error();
		end
		tests_run++;
		if (test_err != 0) tests_failed++;
		$display("test %0d: %0d of %0d commits, %0d stall cycles, %s",
		         test_id, seen, count, stall_cycles, (test_err == 0) ? "ok" : "FAIL");
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			seen         = 0;
			test_err     = 0;
			stall_cycles = 0;
			count        = 0;
			first        = 0;
			// walk down so first lands on the lowest matching line
			for (int i = MAX_LINES-1; i >= 0; i--) begin
				if (test_id != 0 && stim[i*W] == 32'(test_id)) begin
					first = i;
					count++;
				end
			end
		end else begin
			if (stall) stall_cycles++;
			if (halt_status != NO_ERROR && !stall) begin  // halted core must keep stalling
				$display("time %0t: test %0d stall dropped after the core halted",
				         $time, test_id);
				note_error();
			end
			if (commit_valid) check_commit();
			if (test_end) finish_test();
			if (run_end)
				$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		end
	end

endmodule

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
	import core_pkg::*;

	localparam int W           = 8;    // words per stimulus line
	localparam int MAX_LINES   = 64;
	localparam int STALL_LIMIT = 50;   // cycles one instruction may wait on stall
	localparam int DRAIN_LIMIT = 100;  // cycles for a test to commit everything
	localparam int HALT_HOLD   = 10;   // cycles of extra dispatch after a halt

	logic         clock, rst_n;
	logic         disp_valid, stall, commit_valid;
	dispatch_t    disp_inst;
	commit_t      commit;
	halt_status_e halt_status;
	logic [7:0]   test_id;                 // shared with the checker
	logic         test_end, run_end, test_drained;
	int           err_count;
	logic [31:0]  stim [MAX_LINES*W];
	int           line;
	logic [31:0]  last_op;                 // opcode column of the test's last line
	bit           timed_out;               // some wait ran past its limit

	ooo_core i_dut (
		.clock(clock), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_inst(disp_inst),
		.stall(stall), .commit_valid(commit_valid), .commit(commit),
		.halt_status(halt_status)
	);

	tb_checker #(.MAX_LINES(MAX_LINES)) i_checker (
		.clock(clock), .rst_n(rst_n), .stall(stall),
		.commit_valid(commit_valid), .commit(commit), .halt_status(halt_status),
		.test_id(test_id), .test_end(test_end), .run_end(run_end),
		.test_drained(test_drained), .err_count(err_count)
	);

	always #2 clock = ~clock;  // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks that change inputs 0.5 ns after the rising edge
	////////////////////////////////////////////////////////////////////////////
	task automatic apply_reset();
		disp_valid = 1'b0;
		rst_n      = 1'b0;
		repeat (4) @(posedge clock);
		#0.5;
		rst_n = 1'b1;
	endtask

	// hold the line until the core takes it
	task automatic dispatch_line(input int idx);
		int waited;
		bit taken;
		waited           = 0;
		taken            = 1'b0;
		disp_inst.opcode = stim[idx*W+1][3:0];
		disp_inst.dest   = stim[idx*W+2][2:0];
		disp_inst.src_a  = stim[idx*W+3][2:0];
		disp_inst.src_b  = stim[idx*W+4][2:0];
		disp_inst.imm    = stim[idx*W+5];
		disp_valid       = 1'b1;
		while (!taken && !timed_out) begin
			@(negedge clock);
			taken = !stall;  // stall is stable by the falling edge
			@(posedge clock);
			#0.5;
			waited++;
			if (!taken && waited > STALL_LIMIT) begin
				$display("timeout: stall stayed high, the instruction was never taken");
				timed_out = 1'b1;
			end
		end
		disp_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (!test_drained && !timed_out) begin
			@(posedge clock);
			#0.5;
			waited++;
			if (waited > DRAIN_LIMIT) begin
				$display("timeout: the test did not commit all of its instructions");
				timed_out = 1'b1;
			end
		end
	endtask

	// keep offering an add after the halt that must never be taken
	task automatic hold_after_halt();
		disp_inst  = '{opcode: 4'(OP_ADD), dest: 3'd1, src_a: 3'd1, src_b: 3'd1, imm: '0};
		disp_valid = 1'b1;
		repeat (HALT_HOLD) begin
			@(posedge clock);
			#0.5;
		end
		disp_valid = 1'b0;
	endtask

	task automatic end_test();
		test_end = 1'b1;
		@(posedge clock);
		#0.5;
		test_end = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence with one reset per test
	////////////////////////////////////////////////////////////////////////////
	initial begin
		clock      = 1'b0;
		rst_n      = 1'b0;
		disp_valid = 1'b0;
		disp_inst  = '0;
		test_id    = '0;
		test_end   = 1'b0;
		run_end    = 1'b0;
		last_op    = '0;
		timed_out  = 1'b0;
		$readmemh("stim_core.txt", stim);
		line = 0;
		// test 0 ends the file
		while (!timed_out && line < MAX_LINES && stim[line*W] != 0) begin
			test_id = stim[line*W][7:0];
			apply_reset();
			while (!timed_out && line < MAX_LINES && stim[line*W] == 32'(test_id)) begin
				last_op = stim[line*W+1];
				dispatch_line(line);
				line++;
			end
			wait_drained();
			if (!timed_out && last_op >= 32'd7) hold_after_halt();  // halt or illegal
			end_test();
		end
		run_end = 1'b1;
		@(posedge clock);
		#0.5;
		if (!timed_out && err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- stim_core.txt
// columns, all hex: test opcode dest src_a src_b imm exp_we exp_value
// test 0 ends the file, exp_value is ignored when exp_we is 0
// dependent chain
1 5 1 0 0 0000000a 1 0000000a
1 5 2 1 0 00000005 1 0000000f
1 0 3 1 2 00000000 1 00000019
1 1 4 3 1 00000000 1 0000000f
1 3 5 3 1 00000000 1 0000001b
1 2 6 5 4 00000000 1 0000000b
1 0 1 6 6 00000000 1 00000016
1 1 7 0 1 00000000 1 ffffffea
// multiply followed by independent work, r1 renamed under the first mul
2 5 1 0 0 00000007 1 00000007
2 5 2 0 0 00000006 1 00000006
2 6 3 1 2 00000000 1 0000002a
2 5 4 0 0 00000003 1 00000003
2 4 5 4 2 00000000 1 00000005
2 5 1 0 0 00012345 1 00012345
2 6 2 1 1 00000000 1 4b65f099
// dependent multiply burst, longer than the reorder buffer
3 5 1 0 0 00000003 1 00000003
3 5 2 0 0 00000002 1 00000002
3 6 1 1 2 00000000 1 00000006
3 6 1 1 2 00000000 1 0000000c
3 6 1 1 2 00000000 1 00000018
3 6 1 1 2 00000000 1 00000030
3 6 1 1 2 00000000 1 00000060
3 6 1 1 2 00000000 1 000000c0
3 6 1 1 2 00000000 1 00000180
3 6 1 1 2 00000000 1 00000300
// zero register
4 5 0 0 0 00000005 0 00000000
4 5 1 0 0 00000009 1 00000009
4 0 0 1 1 00000000 0 00000000
4 0 2 0 1 00000000 1 00000009
4 6 3 0 1 00000000 1 00000000
// halt
5 5 1 0 0 00000004 1 00000004
5 0 2 1 1 00000000 1 00000008
5 7 0 0 0 00000000 0 00000000
// illegal opcode behind a multiply
6 5 1 0 0 0000000b 1 0000000b
6 6 2 1 1 00000000 1 00000079
6 c 0 0 0 00000000 0 00000000
0 0 0 0 0 00000000 0 00000000

//--- all.f
+incdir+.
core_pkg.sv
core_ctrl.sv
rename_map.sv
phys_regfile.sv
issue_queue.sv
exec_unit.sv
reorder_buffer.sv
ooo_core.sv
tb_checker.sv
tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ooo_core \
	-o tb_ooo_core > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_ooo_core > sim.log 2>&1 || echo "simulation exited with an error: sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
